// File: source/core_pkg.sv
`default_nettype none

package core_pkg;

	// Physical address width of the core.
	localparam int alen = 42;

	// One fetch returns up to two uncompressed instructions.
	localparam int instr_size = 64;

	// Fetches are aligned to the fetch word, so the low bits are dropped.
	localparam int align_bits = $clog2(instr_size / 8);

	localparam int fetch_addr_size = alen - align_bits;

	// Word address of a fetch.
	typedef logic [fetch_addr_size-1:0] fetch_addr_t;

	// Answer to a fetch tagged with the address it belongs to.
	typedef struct packed {
		logic [instr_size-1:0] data;
		fetch_addr_t addr;
	} fetch_rsp_t;

	// Refill request towards the external memory port.
	typedef struct packed {
		fetch_addr_t addr;
	} mem_req_t;

endpackage

`default_nettype wire

// File: source/icache_pkg.sv
`default_nettype none

package icache_pkg;

	// Direct mapped with one fetch word per line.
	localparam int index_bits = 8;
	localparam int lines = 2 ** index_bits;

	// Whatever the index does not cover is kept as tag.
	localparam int tag_size = core_pkg::fetch_addr_size - index_bits;

	// The line memory is built from 16-bit wide block RAMs.
	localparam int bram_blocks = 6;
	localparam int block_width = 16;

	// Only a valid flag is kept per line.
	localparam int flags_size = 1;

	localparam int line_size = bram_blocks * block_width;

	typedef logic [index_bits-1:0] line_index_t;

	// Line layout has the tag on top and the data at the bottom.
	typedef struct packed {
		logic [tag_size-1:0] tag;
		logic valid;
		logic [core_pkg::instr_size-1:0] data;
	} icache_line_t;

endpackage

`default_nettype wire

// File: source/bram.sv
`timescale 1ns/1ps
`default_nettype none

module bram #(
	parameter type payload_t = icache_pkg::icache_line_t,
	parameter int depth = icache_pkg::lines
) (
	input wire logic clk,
	input wire logic write_enable,
	input wire icache_pkg::line_index_t waddr,
	input wire payload_t wdata,
	input wire icache_pkg::line_index_t raddr,
	output payload_t rdata
);

	localparam int bw = icache_pkg::block_width;
	localparam int width = $bits(payload_t);

	// Payload is rounded up to whole blocks.
	localparam int nblocks = (width + bw - 1) / bw;

	logic [nblocks*bw-1:0] wdata_bits;
	logic [nblocks*bw-1:0] rdata_bits;
	logic collide;

	// Spare bits of the last block stay zero.
	always_comb begin
		wdata_bits = '0;
		wdata_bits[width-1:0] = wdata;
	end

	// A read of the line being written returns the new value.
	assign collide = write_enable && waddr == raddr;

	for (genvar b = 0; b < nblocks; b++) begin : g_block
		logic [bw-1:0] mem [depth];
		logic [bw-1:0] q;

		always_ff @(posedge clk) begin
			if (write_enable) begin
				mem[waddr] <= wdata_bits[b*bw +: bw];
			end
			if (collide) begin
				q <= wdata_bits[b*bw +: bw];
			end else begin
				q <= mem[raddr];
			end
		end

		assign rdata_bits[b*bw +: bw] = q;
	end

	assign rdata = payload_t'(rdata_bits[width-1:0]);

endmodule

`default_nettype wire

// File: source/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache (
	input wire logic clk,
	input wire logic rst_n,
	input wire core_pkg::fetch_addr_t rd_addr,
	input wire logic wr_en,
	input wire logic wr_clear,
	input wire core_pkg::fetch_addr_t wr_addr,
	input wire logic [core_pkg::instr_size-1:0] wr_data,
	output logic [core_pkg::instr_size-1:0] rd_data,
	output logic hit
);

	// Line geometry is tied to the address width.
	if (core_pkg::alen != 42) begin : g_bad_alen
		$error("icache geometry assumes a 42-bit physical address");
	end
	if (icache_pkg::line_size != $bits(icache_pkg::icache_line_t)) begin : g_bad_line
		$error("icache line does not fill the block RAMs exactly");
	end
	if (icache_pkg::line_size != icache_pkg::tag_size + icache_pkg::flags_size
			+ core_pkg::instr_size) begin : g_bad_flags
		$error("icache line size is inconsistent with tag, flags and data");
	end

	icache_pkg::icache_line_t wline;
	icache_pkg::icache_line_t rline;
	icache_pkg::line_index_t windex;
	icache_pkg::line_index_t rindex;
	logic [icache_pkg::tag_size-1:0] rd_tag;
	logic [icache_pkg::tag_size-1:0] rd_tag_q;

	always_comb begin
		windex = wr_addr[icache_pkg::index_bits-1:0];
		wline.tag = wr_addr[core_pkg::fetch_addr_size-1 -: icache_pkg::tag_size];
		// A cleared line is stored with valid low.
		wline.valid = !wr_clear;
		wline.data = wr_data;

		rindex = rd_addr[icache_pkg::index_bits-1:0];
		rd_tag = rd_addr[core_pkg::fetch_addr_size-1 -: icache_pkg::tag_size];
	end

	bram #(
		.payload_t(icache_pkg::icache_line_t),
		.depth(icache_pkg::lines)
	) u_bram (
		.clk(clk),
		.write_enable(wr_en),
		.waddr(windex),
		.wdata(wline),
		.raddr(rindex),
		.rdata(rline)
	);

	// Tag travels alongside the RAM read so both meet on the next cycle.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_tag_q <= '0;
		end else begin
			rd_tag_q <= rd_tag;
		end
	end

	assign rd_data = rline.data;
	assign hit = rline.valid && rline.tag == rd_tag_q;

endmodule

`default_nettype wire

// File: source/icache_refill.sv
`timescale 1ns/1ps
`default_nettype none

module icache_refill (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic fetch_req,
	input wire core_pkg::fetch_addr_t fetch_addr,
	input wire logic hit,
	input wire logic [core_pkg::instr_size-1:0] rd_data,
	input wire logic mem_rsp_valid,
	input wire logic [core_pkg::instr_size-1:0] mem_rsp_data,
	output core_pkg::fetch_addr_t rd_addr,
	output logic wr_en,
	output logic wr_clear,
	output core_pkg::fetch_addr_t wr_addr,
	output logic [core_pkg::instr_size-1:0] wr_data,
	output logic fetch_rsp_valid,
	output core_pkg::fetch_rsp_t fetch_rsp,
	output logic mem_req_valid,
	output core_pkg::mem_req_t mem_req,
	output logic busy
);

	typedef enum logic [1:0] {
		s_sweep,
		s_idle,
		s_wait_mem,
		s_replay
	} state_t;

	state_t state;
	state_t state_d;
	icache_pkg::line_index_t sweep_idx;
	logic sweep_done;

	// Lookup stage holds the request whose hit flag is on the RAM output now.
	logic lk_valid;
	logic lk_valid_d;
	core_pkg::fetch_addr_t lk_addr;
	logic lk_miss;

	// Younger request caught in the RAM read when a miss was seen.
	logic park_valid;
	logic park_valid_d;
	core_pkg::fetch_addr_t park_addr;

	core_pkg::fetch_addr_t miss_addr;
	logic [core_pkg::instr_size-1:0] fill_data;

	assign lk_miss = state == s_idle && lk_valid && !hit;
	assign sweep_done = sweep_idx == icache_pkg::line_index_t'(icache_pkg::lines - 1);

	always_comb begin
		state_d = state;
		lk_valid_d = 1'b0;
		park_valid_d = park_valid;
		unique case (state)
			s_sweep: begin
				if (sweep_done) begin
					state_d = s_idle;
				end
			end
			s_idle: begin
				if (lk_miss) begin
					state_d = s_wait_mem;
					park_valid_d = fetch_req;
				end else begin
					lk_valid_d = fetch_req;
				end
			end
			s_wait_mem: begin
				if (mem_rsp_valid) begin
					state_d = s_replay;
				end
			end
			s_replay: begin
				// In the fill cycle the parked request is re-read behind the write.
				state_d = s_idle;
				lk_valid_d = park_valid;
				park_valid_d = 1'b0;
			end
			default: begin
				state_d = s_sweep;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= s_sweep;
			sweep_idx <= '0;
			lk_valid <= 1'b0;
			park_valid <= 1'b0;
		end else begin
			state <= state_d;
			lk_valid <= lk_valid_d;
			park_valid <= park_valid_d;
			if (state == s_sweep) begin
				sweep_idx <= sweep_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == s_replay) begin
			lk_addr <= park_addr;
		end else if (fetch_req) begin
			lk_addr <= fetch_addr;
		end
		if (lk_miss) begin
			miss_addr <= lk_addr;
			park_addr <= fetch_addr;
		end
		if (state == s_wait_mem && mem_rsp_valid) begin
			fill_data <= mem_rsp_data;
		end
	end

	// RAM ports.
	assign rd_addr = state == s_sweep ? core_pkg::fetch_addr_t'(sweep_idx) :
		state == s_replay ? park_addr : fetch_addr;
	assign wr_en = state == s_sweep || state == s_replay;
	assign wr_clear = state == s_sweep;
	assign wr_addr = state == s_sweep ? core_pkg::fetch_addr_t'(sweep_idx) : miss_addr;
	assign wr_data = fill_data;

	// Fill data goes out first and hits in the lookup stage otherwise.
	always_comb begin
		fetch_rsp_valid = state == s_replay || (state == s_idle && lk_valid && hit);
		if (state == s_replay) begin
			fetch_rsp.data = fill_data;
			fetch_rsp.addr = miss_addr;
		end else begin
			fetch_rsp.data = rd_data;
			fetch_rsp.addr = lk_addr;
		end
	end

	assign mem_req_valid = lk_miss;
	assign mem_req.addr = lk_addr;
	assign busy = state != s_idle || lk_miss;

endmodule

`default_nettype wire

// File: source/ifetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module ifetch_top (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic fetch_req,
	input wire core_pkg::fetch_addr_t fetch_addr,
	input wire logic mem_rsp_valid,
	input wire logic [core_pkg::instr_size-1:0] mem_rsp_data,
	output logic fetch_rsp_valid,
	output core_pkg::fetch_rsp_t fetch_rsp,
	output logic busy,
	output logic mem_req_valid,
	output core_pkg::mem_req_t mem_req
);

	core_pkg::fetch_addr_t rd_addr;
	core_pkg::fetch_addr_t wr_addr;
	logic [core_pkg::instr_size-1:0] rd_data;
	logic [core_pkg::instr_size-1:0] wr_data;
	logic hit;
	logic wr_en;
	logic wr_clear;

	icache u_icache (
		.clk(clk),
		.rst_n(rst_n),
		.rd_addr(rd_addr),
		.wr_en(wr_en),
		.wr_clear(wr_clear),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_data(rd_data),
		.hit(hit)
	);

	// Refill unit owns both cache ports and the external handshakes.
	icache_refill u_refill (
		.clk(clk),
		.rst_n(rst_n),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.hit(hit),
		.rd_data(rd_data),
		.mem_rsp_valid(mem_rsp_valid),
		.mem_rsp_data(mem_rsp_data),
		.rd_addr(rd_addr),
		.wr_en(wr_en),
		.wr_clear(wr_clear),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.fetch_rsp_valid(fetch_rsp_valid),
		.fetch_rsp(fetch_rsp),
		.mem_req_valid(mem_req_valid),
		.mem_req(mem_req),
		.busy(busy)
	);

endmodule

`default_nettype wire

// File: dv/ifetch_chk.sv
`timescale 1ns/1ps
`default_nettype none

module ifetch_chk (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic fetch_req,
	input wire logic busy,
	input wire logic mem_req_valid,
	input wire logic fetch_rsp_valid
);

	// The requester sees busy one cycle late, so a strobe may only follow a cycle with busy low.
	// This still lets one younger request slip in behind a miss.
	a_req_not_busy: assert property (
		@(posedge clk) disable iff (!rst_n) fetch_req |-> !$past(busy)
	) else $error("fetch_req strobed while busy was high");

	// Only one refill is ever outstanding.
	a_single_mem_req: assert property (
		@(posedge clk) disable iff (!rst_n) mem_req_valid |=> !mem_req_valid
	) else $error("mem_req_valid high in two consecutive cycles");

	a_quiet_after_reset: assert property (
		@(posedge clk) $rose(rst_n) |-> !mem_req_valid && !fetch_rsp_valid
	) else $error("mem_req_valid or fetch_rsp_valid high right after reset");

endmodule

`default_nettype wire

// File: dv/ifetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ifetch_tb;

	// About 2300 fetches take some 9000 cycles when a quarter of them refill in up to 12 cycles.
	// The limit adds the sweep and roughly twice that as margin.
	localparam int max_cycles = 20000;

	logic clk;
	logic rst_n;
	logic fetch_req;
	core_pkg::fetch_addr_t fetch_addr;
	logic mem_rsp_valid;
	logic [core_pkg::instr_size-1:0] mem_rsp_data;
	logic fetch_rsp_valid;
	core_pkg::fetch_rsp_t fetch_rsp;
	logic busy;
	logic mem_req_valid;
	core_pkg::mem_req_t mem_req;

	logic [31:0] lfsr;
	int cycle;
	int errors;
	int tests;
	int failed_tests;
	int test_start;
	int mem_reqs;
	int exp_mem_reqs;

	// Reference cache state and expected traffic.
	logic [icache_pkg::tag_size-1:0] model_tag [icache_pkg::lines];
	logic model_valid [icache_pkg::lines];
	core_pkg::fetch_addr_t rsp_q[$];
	int rsp_cycle_q[$];
	logic rsp_fast_q[$];
	core_pkg::fetch_addr_t memreq_q[$];

	logic busy_prev;
	logic rsp_prev;
	logic last_issue_miss;
	int last_issue_cycle;

	// Memory responder state.
	logic mem_pend;
	int mem_cnt;
	core_pkg::fetch_addr_t mem_addr;

	ifetch_top uut (
		.clk(clk),
		.rst_n(rst_n),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.mem_rsp_valid(mem_rsp_valid),
		.mem_rsp_data(mem_rsp_data),
		.fetch_rsp_valid(fetch_rsp_valid),
		.fetch_rsp(fetch_rsp),
		.busy(busy),
		.mem_req_valid(mem_req_valid),
		.mem_req(mem_req)
	);

	bind ifetch_top ifetch_chk u_chk (
		.clk(clk),
		.rst_n(rst_n),
		.fetch_req(fetch_req),
		.busy(busy),
		.mem_req_valid(mem_req_valid),
		.fetch_rsp_valid(fetch_rsp_valid)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// Ends the run once the cycle count passes the limit.
	initial begin
		wait (cycle > max_cycles);
		$display("Timeout: the run did not finish within %0d cycles", max_cycles);
		$display("Test failed");
		$finish;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int unsigned rand_bits(input int n);
		int unsigned r;
		r = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			r = (r << 1) | 32'(lfsr[0]);
		end
		return r;
	endfunction

	// Memory contents as a function of the address.
	function automatic logic [63:0] mix(input core_pkg::fetch_addr_t a);
		logic [63:0] x;
		x = {25'd0, a} ^ 64'h5a5a_c3c3_0f0f_9696;
		x = x * 64'h9e37_79b9_7f4a_7c15;
		return x ^ ({25'd0, a} << 24);
	endfunction

	// Small pool of 16 indices with mostly one tag.
	// The other tag differs in its top bit.
	function automatic core_pkg::fetch_addr_t pool_addr();
		logic [icache_pkg::tag_size-1:0] tag;
		logic [icache_pkg::index_bits-1:0] idx;
		tag = 31'h0123_4567;
		idx = 8'h40 + 8'(rand_bits(4));
		if (rand_bits(3) == 0) begin
			tag[icache_pkg::tag_size-1] = ~tag[icache_pkg::tag_size-1];
		end
		return {tag, idx};
	endfunction

	task automatic check_fail(input string msg);
		$display("ERROR %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic model_issue(input core_pkg::fetch_addr_t addr);
		logic [icache_pkg::index_bits-1:0] idx;
		logic [icache_pkg::tag_size-1:0] tag;
		logic miss;
		logic parked;
		idx = addr[icache_pkg::index_bits-1:0];
		tag = addr[core_pkg::fetch_addr_size-1 -: icache_pkg::tag_size];
		miss = !model_valid[idx] || model_tag[idx] != tag;
		// A request right behind a miss is parked and answered late.
		parked = last_issue_miss && last_issue_cycle == cycle - 1;
		if (miss) begin
			model_valid[idx] = 1'b1;
			model_tag[idx] = tag;
			memreq_q.push_back(addr);
			exp_mem_reqs++;
		end
		rsp_q.push_back(addr);
		rsp_cycle_q.push_back(cycle);
		rsp_fast_q.push_back(!miss && !parked);
		last_issue_miss = miss;
		last_issue_cycle = cycle;
	endtask

	task automatic check_outputs();
		core_pkg::fetch_addr_t exp;
		int c;
		logic fast;
		if (mem_req_valid) begin
			mem_reqs++;
			if (memreq_q.size() == 0) begin
				check_fail($sformatf("unexpected mem_req for %h", mem_req.addr));
			end else begin
				exp = memreq_q.pop_front();
				if (mem_req.addr != exp) begin
					check_fail($sformatf("mem_req addr %h, expected %h", mem_req.addr, exp));
				end
			end
			if (mem_pend) begin
				check_fail("mem_req while another refill is outstanding");
			end
			mem_pend = 1'b1;
			mem_cnt = 1 + int'(rand_bits(3));
			mem_addr = mem_req.addr;
		end
		if (rsp_prev && !fetch_rsp_valid) begin
			check_fail("no fetch response the cycle after mem_rsp_valid");
		end
		if (fetch_rsp_valid) begin
			if (rsp_q.size() == 0) begin
				check_fail($sformatf("unexpected fetch response for %h", fetch_rsp.addr));
			end else begin
				exp = rsp_q.pop_front();
				c = rsp_cycle_q.pop_front();
				fast = rsp_fast_q.pop_front();
				if (fetch_rsp.addr != exp) begin
					check_fail($sformatf("response addr %h, expected %h", fetch_rsp.addr, exp));
				end
				if (fetch_rsp.data != mix(exp)) begin
					check_fail($sformatf("response data %h, expected %h", fetch_rsp.data,
						mix(exp)));
				end
				if (fast && cycle != c + 1) begin
					check_fail($sformatf("hit answered after %0d cycles", cycle - c));
				end
			end
		end
	endtask

	// One clock cycle that drives after the rising edge and checks at the falling edge.
	task automatic step(input logic req, input core_pkg::fetch_addr_t addr);
		@(posedge clk);
		#1;
		cycle++;
		fetch_req = req;
		fetch_addr = addr;
		mem_rsp_valid = 1'b0;
		if (mem_pend) begin
			mem_cnt--;
			if (mem_cnt == 0) begin
				mem_pend = 1'b0;
				mem_rsp_valid = 1'b1;
				mem_rsp_data = mix(mem_addr);
			end
		end
		if (req) begin
			model_issue(addr);
		end
		@(negedge clk);
		check_outputs();
		rsp_prev = mem_rsp_valid;
		busy_prev = busy;
	endtask

	task automatic fetch(input core_pkg::fetch_addr_t addr);
		while (busy_prev) begin
			step(1'b0, '0);
		end
		step(1'b1, addr);
	endtask

	task automatic finish_test(input string name);
		while (rsp_q.size() != 0 || mem_pend || busy_prev) begin
			step(1'b0, '0);
		end
		if (memreq_q.size() != 0) begin
			check_fail("an expected memory request was never issued");
			memreq_q.delete();
		end
		if (mem_reqs != exp_mem_reqs) begin
			check_fail($sformatf("%0d memory requests, expected %0d", mem_reqs, exp_mem_reqs));
		end
		tests++;
		if (errors != test_start) begin
			failed_tests++;
		end
		$display("%s: %s (%0d errors)", name, errors == test_start ? "ok" : "FAILED",
			errors - test_start);
		test_start = errors;
	endtask

	initial begin
		core_pkg::fetch_addr_t a;
		core_pkg::fetch_addr_t b;
		int n;
		lfsr = 32'h3bf47e3d;
		rst_n = 1'b0;
		fetch_req = 1'b0;
		fetch_addr = '0;
		mem_rsp_valid = 1'b0;
		mem_rsp_data = '0;
		cycle = 0;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		test_start = 0;
		mem_reqs = 0;
		exp_mem_reqs = 0;
		busy_prev = 1'b1;
		rsp_prev = 1'b0;
		last_issue_miss = 1'b0;
		last_issue_cycle = -10;
		mem_pend = 1'b0;
		mem_cnt = 0;
		mem_addr = '0;
		for (int i = 0; i < icache_pkg::lines; i++) begin
			model_valid[i] = 1'b0;
			model_tag[i] = '0;
		end

		repeat (3) @(posedge clk);
		@(negedge clk);
		if (!busy) begin
			check_fail("busy low during reset");
		end
		@(posedge clk);
		#1;
		rst_n = 1'b1;

		n = 0;
		while (busy_prev && n < 300) begin
			step(1'b0, '0);
			n++;
		end
		if (n > 260) begin
			check_fail($sformatf("busy still high %0d cycles after reset", n));
		end
		a = pool_addr();
		fetch(a);
		finish_test("reset sweep");

		a = {31'h2a5a_1234, 8'h17};
		fetch(a);
		finish_test("cold miss");

		fetch(a);
		fetch(a);
		finish_test("hit");

		// Same index with tags that differ only in the top bit and then in low bits.
		b = a ^ {1'b1, 38'd0};
		fetch(b);
		fetch(a);
		fetch(b);
		fetch(a ^ {31'h0000_0005, 8'd0});
		fetch(a);
		finish_test("conflict");

		repeat (200) begin
			fetch(pool_addr());
		end
		finish_test("back-to-back");

		repeat (2000) begin
			fetch(pool_addr());
			if (rand_bits(3) == 0) begin
				step(1'b0, '0);
			end
		end
		finish_test("random soak");

		$display("Summary: %0d tests, %0d failed, %0d errors, %0d memory requests",
			tests, failed_tests, errors, mem_reqs);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
source/core_pkg.sv
source/icache_pkg.sv
source/bram.sv
source/icache.sv
source/icache_refill.sv
source/ifetch_top.sv
dv/ifetch_chk.sv
dv/ifetch_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the instruction fetch testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module ifetch_tb -o ifetch_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/ifetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Test passed$" sim.log; then
	echo "PASS"
	exit 0
fi

echo "FAIL"
exit 1
